// File: Bender.yml
package:
  name: gpio_mesh

sources:
  - design/gpio_pkg.sv
  - design/gpio_packet_decode.sv
  - design/gpio_pin_sync.sv
  - design/gpio_regs.sv
  - design/gpio_readback.sv
  - design/gpio_mesh.sv
  - target: test
    files:
      - tests/gpio_mesh_props.sv
      - tests/gpio_mesh_tb.sv

// File: design/gpio_mesh.sv
/*
 * GPIO block on a 104-bit mesh port, N pins from 1 to 32.
 * No pad cells and no tristate, gpio_dir goes to the pad ring.
 * wait_out follows wait_in combinationally.
 */
`default_nettype none

module gpio_mesh
   import gpio_pkg::*;
#(
   parameter int N = 24                  // Number of pins
) (
   input  logic          clk,
   input  logic          nreset,         // Asynchronous, active low
   input  logic          access_in,      // Request valid
   input  emesh_packet_t packet_in,
   output logic          wait_out,
   output logic          access_out,     // Response valid
   output emesh_packet_t packet_out,
   input  logic          wait_in,
   input  logic [N-1:0]  gpio_in,        // Pin inputs
   output logic [N-1:0]  gpio_out,       // Pin output data
   output logic [N-1:0]  gpio_dir,       // 1 = output
   output logic          gpio_irq        // Unmasked interrupt
);

   gpio_req_t    req;
   logic [N-1:0] pin_sync;
   logic [N-1:0] pin_event;
   logic [N-1:0] itype;
   logic [N-1:0] ipol;
   logic [31:0]  read_data;

   // ########################################################################
   // Input side
   // ########################################################################
   gpio_packet_decode u_decode (
      .access_in (access_in),
      .packet_in (packet_in),
      .req       (req)
   );

   // ########################################################################
   // Pins and registers
   // ########################################################################
   gpio_pin_sync #(.N(N)) u_pin_sync (
      .clk       (clk),
      .nreset    (nreset),
      .gpio_in   (gpio_in),
      .itype     (itype),
      .ipol      (ipol),
      .pin_sync  (pin_sync),
      .pin_event (pin_event)
   );

   gpio_regs #(.N(N)) u_regs (
      .clk       (clk),
      .nreset    (nreset),
      .req       (req),
      .pin_sync  (pin_sync),
      .pin_event (pin_event),
      .itype     (itype),
      .ipol      (ipol),
      .gpio_out  (gpio_out),
      .gpio_dir  (gpio_dir),
      .gpio_irq  (gpio_irq),
      .read_data (read_data)
   );

   // ########################################################################
   // Output side
   // ########################################################################
   gpio_readback u_readback (
      .clk        (clk),
      .nreset     (nreset),
      .rd         (req.rd),
      .srcaddr    (req.srcaddr),
      .read_data  (read_data),
      .wait_in    (wait_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

`default_nettype wire

// File: design/gpio_packet_decode.sv
/*
 * Input side of the mesh port. Purely combinational.
 * Every access_in cycle is taken as one request, no double-word support.
 * ctrlmode and datamode are ignored.
 */
`default_nettype none

module gpio_packet_decode
   import gpio_pkg::*;
(
   input  logic          access_in,      // Request valid this cycle
   input  emesh_packet_t packet_in,      // Incoming mesh packet
   output gpio_req_t     req             // Decoded view for later blocks
);

   logic is_write;                       // Write bit of the packet
   logic [3:0] code;                     // Raw register code

   assign is_write = packet_in.write;
   assign code     = packet_in.dstaddr[6:3];

   // ########################################################################
   // Request unpacking
   // ########################################################################
   always_comb begin
      req         = '0;
      req.wr      = access_in & is_write;     // Write strobe
      req.rd      = access_in & ~is_write;    // Read strobe

      // Unused codes pass through, regs treats them as no register
      req.reg_sel = gpio_reg_e'(code);

      req.wdata   = packet_in.data;
      req.srcaddr = packet_in.srcaddr;        // Kept for the response
   end

endmodule

`default_nettype wire

// File: design/gpio_pin_sync.sv
/*
 * Two-flop synchronizer for the pin inputs plus interrupt event detect.
 * Edge events compare against the previous synchronized value.
 * Level events assert for every cycle the pin sits at its active level.
 */
`default_nettype none

module gpio_pin_sync #(
   parameter int N = 24                  // Number of pins
) (
   input  logic         clk,
   input  logic         nreset,
   input  logic [N-1:0] gpio_in,         // Raw pin inputs, asynchronous
   input  logic [N-1:0] itype,           // 0 = edge, 1 = level
   input  logic [N-1:0] ipol,            // 1 = rising or high
   output logic [N-1:0] pin_sync,        // Synchronized pins
   output logic [N-1:0] pin_event        // Per pin interrupt event
);

   logic [N-1:0] meta;                   // First synchronizer stage
   logic [N-1:0] prev;                   // Shadow of last pin_sync
   logic [N-1:0] rise;
   logic [N-1:0] fall;

   // ########################################################################
   // Synchronizer and shadow
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         meta     <= '0;
         pin_sync <= '0;
         prev     <= '0;
      end else begin
         meta     <= gpio_in;
         pin_sync <= meta;
         prev     <= pin_sync;           // One cycle behind pin_sync
      end
   end

   // ########################################################################
   // Event select
   // ########################################################################
   assign rise = pin_sync & ~prev;
   assign fall = ~pin_sync & prev;

   assign pin_event = (~itype &  ipol &  rise)       // Edge, rising
                    | (~itype & ~ipol &  fall)       // Edge, falling
                    | ( itype &  ipol &  pin_sync)   // Level, high
                    | ( itype & ~ipol & ~pin_sync);  // Level, low

endmodule

`default_nettype wire

// File: design/gpio_pkg.sv
/*
 * Shared types for the GPIO mesh block.
 * Packet layout is fixed for a 32-bit mesh address, 104 bits in total.
 * Register code comes from dstaddr[6:3]. Codes 11 to 15 are unused.
 */
`default_nettype none

package gpio_pkg;

   localparam int GPIO_MAX_PINS = 32;    // Upper bound for N

   // ########################################################################
   // Mesh packet
   // ########################################################################
   typedef struct packed {
      logic [31:0] srcaddr;              // Return address for reads
      logic [31:0] data;                 // Write data or read data
      logic [31:0] dstaddr;              // Target register address
      logic [4:0]  ctrlmode;             // Not used by this block
      logic [1:0]  datamode;             // Not used, no double-word access
      logic        write;                // 1 = write, 0 = read
   } emesh_packet_t;

   // ########################################################################
   // Register map
   // ########################################################################
   typedef enum logic [3:0] {
      GPIO_DIR     = 4'd0,               // Direction, 1 = output
      GPIO_IN      = 4'd1,               // Synchronized pins, read only
      GPIO_OUT     = 4'd2,               // Output data
      GPIO_OUTCLR  = 4'd3,               // Clear bits of OUT
      GPIO_OUTSET  = 4'd4,               // Set bits of OUT
      GPIO_OUTXOR  = 4'd5,               // Toggle bits of OUT
      GPIO_IMASK   = 4'd6,               // 1 = interrupt masked
      GPIO_ITYPE   = 4'd7,               // 0 = edge, 1 = level
      GPIO_IPOL    = 4'd8,               // 1 = rising or high
      GPIO_ILAT    = 4'd9,               // Interrupt latch
      GPIO_ILATCLR = 4'd10               // Clear latch bits
   } gpio_reg_e;

   // ########################################################################
   // Decoded request, valid for the cycle of access_in
   // ########################################################################
   typedef struct packed {
      logic        wr;                   // Write strobe
      logic        rd;                   // Read strobe
      gpio_reg_e   reg_sel;              // Target register
      logic [31:0] wdata;                // Write data
      logic [31:0] srcaddr;              // Reply goes here
   } gpio_req_t;

endpackage

`default_nettype wire

// File: design/gpio_readback.sv
/*
 * Builds the read response packet and holds it under wait_in.
 * Assumes the sender obeys wait_out, so no read arrives while stalled.
 * Response source address, datamode and ctrlmode are always zero.
 */
`default_nettype none

module gpio_readback
   import gpio_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   input  logic          rd,             // Read strobe of the request
   input  logic [31:0]   srcaddr,        // Return address of the request
   input  logic [31:0]   read_data,      // Valid one cycle after rd
   input  logic          wait_in,        // Pushback from the mesh
   output logic          wait_out,       // Pushback to the sender
   output logic          access_out,     // Response valid
   output emesh_packet_t packet_out      // Response packet
);

   logic        rd_q;                    // rd aligned with read_data
   logic [31:0] srcaddr_q;
   logic        stall;                   // Response held by the mesh

   assign stall    = access_out & wait_in;
   assign wait_out = wait_in;            // Pushback passes straight through

   // ########################################################################
   // Alignment stage, frozen while stalled
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         rd_q <= 1'b0;
      else if (!stall)
         rd_q <= rd;
   end

   always_ff @(posedge clk) begin
      if (rd && !stall)
         srcaddr_q <= srcaddr;
   end

   // ########################################################################
   // Response register
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         access_out <= 1'b0;
      else if (!stall)
         access_out <= rd_q;             // Drops after consume if idle
   end

   always_ff @(posedge clk) begin
      if (rd_q && !stall) begin
         packet_out          <= '0;
         packet_out.write    <= 1'b1;
         packet_out.dstaddr  <= srcaddr_q;    // Back to the requester
         packet_out.data     <= read_data;
      end
   end

endmodule

`default_nettype wire

// File: design/gpio_regs.sv
/*
 * Register file of the GPIO block.
 * Only the low N bits of write data are used. Reads zero-extend to 32 bits.
 * Write-only codes and unused codes read as zero.
 * A new pin event wins over ILATCLR in the same cycle.
 */
`default_nettype none

module gpio_regs
   import gpio_pkg::*;
#(
   parameter int N = 24                  // Number of pins
) (
   input  logic         clk,
   input  logic         nreset,
   input  gpio_req_t    req,             // Decoded request
   input  logic [N-1:0] pin_sync,        // Synchronized pins for GPIO_IN
   input  logic [N-1:0] pin_event,       // Events from the pin block
   output logic [N-1:0] itype,
   output logic [N-1:0] ipol,
   output logic [N-1:0] gpio_out,        // Pin output data
   output logic [N-1:0] gpio_dir,        // Pin direction, 1 = output
   output logic         gpio_irq,        // OR of unmasked latch bits
   output logic [31:0]  read_data        // Valid one cycle after req.rd
);

   if (N < 1 || N > GPIO_MAX_PINS) begin : g_bad_n
      $fatal(1, "gpio_regs N out of range");
   end

   logic [N-1:0] wdata;
   logic [N-1:0] imask;
   logic [N-1:0] ilat;
   logic [N-1:0] out_next;               // Result of the OUT operations
   logic [N-1:0] ilat_clr;               // Bits cleared by ILATCLR
   logic [N-1:0] rd_mux;
   logic         dir_we;
   logic         imask_we;
   logic         itype_we;
   logic         ipol_we;

   assign wdata = req.wdata[N-1:0];      // Upper bits dropped

   // ########################################################################
   // Write decode
   // ########################################################################
   always_comb begin
      dir_we   = 1'b0;
      imask_we = 1'b0;
      itype_we = 1'b0;
      ipol_we  = 1'b0;
      out_next = gpio_out;               // Hold unless an OUT op hits
      ilat_clr = '0;
      if (req.wr) begin
         case (req.reg_sel)
            GPIO_DIR:     dir_we   = 1'b1;
            GPIO_OUT:     out_next = wdata;
            GPIO_OUTCLR:  out_next = gpio_out & ~wdata;
            GPIO_OUTSET:  out_next = gpio_out | wdata;
            GPIO_OUTXOR:  out_next = gpio_out ^ wdata;
            GPIO_IMASK:   imask_we = 1'b1;
            GPIO_ITYPE:   itype_we = 1'b1;
            GPIO_IPOL:    ipol_we  = 1'b1;
            GPIO_ILATCLR: ilat_clr = wdata;
            default:      ;              // GPIO_IN, ILAT, unused codes
         endcase
      end
   end

   // ########################################################################
   // Control registers
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         gpio_dir <= '0;
         gpio_out <= '0;
         imask    <= '1;                 // All interrupts masked
         itype    <= '0;
         ipol     <= '0;
         ilat     <= '0;
      end else begin
         gpio_out <= out_next;
         if (dir_we)   gpio_dir <= wdata;
         if (imask_we) imask    <= wdata;
         if (itype_we) itype    <= wdata;
         if (ipol_we)  ipol     <= wdata;
         ilat <= (ilat & ~ilat_clr) | pin_event;   // Event wins
      end
   end

   assign gpio_irq = |(ilat & ~imask);

   // ########################################################################
   // Readback
   // ########################################################################
   always_comb begin
      case (req.reg_sel)
         GPIO_DIR:   rd_mux = gpio_dir;
         GPIO_IN:    rd_mux = pin_sync;
         GPIO_IMASK: rd_mux = imask;
         GPIO_ITYPE: rd_mux = itype;
         GPIO_IPOL:  rd_mux = ipol;
         GPIO_ILAT:  rd_mux = ilat;
         default:    rd_mux = '0;        // Write-only or unused
      endcase
   end

   // Captures the register as it was at the request edge
   always_ff @(posedge clk) begin
      if (req.rd)
         read_data <= 32'(rd_mux);       // Zero-extend
   end

endmodule

`default_nettype wire

// File: gpio_mesh.f
design/gpio_pkg.sv
design/gpio_packet_decode.sv
design/gpio_pin_sync.sv
design/gpio_regs.sv
design/gpio_readback.sv
design/gpio_mesh.sv
tests/gpio_mesh_props.sv
tests/gpio_mesh_tb.sv

// File: tests/gpio_mesh_props.sv
/*
 * Concurrent checks bound into every gpio_mesh instance.
 * Reads the latch and mask inside the register block.
 */
`default_nettype none

module gpio_mesh_props
   import gpio_pkg::*;
#(
   parameter int N = 24                  // Number of pins
) (
   input logic          clk,
   input logic          nreset,
   input logic          access_out,
   input logic          wait_in,
   input emesh_packet_t packet_out,
   input logic          gpio_irq,
   input logic [N-1:0]  ilat,            // Interrupt latch of u_regs
   input logic [N-1:0]  imask            // Interrupt mask of u_regs
);

   timeunit 1ns;
   timeprecision 1ps;

   // No response while in reset
   a_idle_in_reset : assert property (@(posedge clk) !nreset |-> !access_out)
      else $error("access_out high during reset");

   // Held response keeps valid and payload
   a_hold : assert property (@(posedge clk) disable iff (!nreset)
      access_out && wait_in |=> $stable(access_out) && $stable(packet_out))
      else $error("Response changed while wait_in was high");

   a_irq : assert property (@(posedge clk) disable iff (!nreset)
      gpio_irq == |(ilat & ~imask))    // Unmasked latch bits only
      else $error("gpio_irq does not match the unmasked latch bits");

endmodule

bind gpio_mesh gpio_mesh_props #(.N(N)) u_props (
   .clk        (clk),
   .nreset     (nreset),
   .access_out (access_out),
   .wait_in    (wait_in),
   .packet_out (packet_out),
   .gpio_irq   (gpio_irq),
   .ilat       (u_regs.ilat),
   .imask      (u_regs.imask)
);

`default_nettype wire

// File: tests/gpio_mesh_tb.sv
/*
 * Testbench for gpio_mesh with 24 pins.
 * One read in flight at a time, responses checked in request order.
 * Interrupt checks assume pins stay steady 5 cycles after each change.
 */
`default_nettype none

module gpio_mesh_tb
   import gpio_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N = 24;

   logic          clk;
   logic          nreset;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;
   logic [N-1:0]  gpio_in;
   logic [N-1:0]  gpio_out;
   logic [N-1:0]  gpio_dir;
   logic          gpio_irq;

   // Reference model state
   logic [N-1:0]  m_dir;
   logic [N-1:0]  m_out;
   logic [N-1:0]  m_imask;
   logic [N-1:0]  m_itype;
   logic [N-1:0]  m_ipol;
   logic [N-1:0]  m_ilat;
   logic [N-1:0]  m_pins;                // Last value driven on gpio_in

   logic [63:0]   exp_q[$];              // {dstaddr, data} per read
   logic          pins_pending;          // Write done, outputs to check
   int            value_errs = 0;
   int            proto_errs = 0;
   int            n_trans = 0;
   int            n_reads = 0;
   int            resp_count = 0;
   int            cycles = 0;
   int unsigned   seed;

   gpio_mesh #(.N(N)) dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;           // 40 ns period
   end

   // ########################################################################
   // Reference model
   // ########################################################################
   function automatic logic [N-1:0] out_op(gpio_reg_e sel, logic [N-1:0] cur,
                                           logic [N-1:0] d);
      case (sel)
         GPIO_OUT:    return d;
         GPIO_OUTCLR: return cur & ~d;
         GPIO_OUTSET: return cur | d;
         GPIO_OUTXOR: return cur ^ d;
         default:     return cur;
      endcase
   endfunction

   // Pins sitting at their active level, level mode only
   function automatic logic [N-1:0] level_hits(logic [N-1:0] typ, logic [N-1:0] pol,
                                               logic [N-1:0] pins);
      return typ & ~(pins ^ pol);
   endfunction

   function automatic logic [N-1:0] edge_hits(logic [N-1:0] typ, logic [N-1:0] pol,
                                              logic [N-1:0] old, logic [N-1:0] nxt);
      return ~typ & ((pol & nxt & ~old) | (~pol & ~nxt & old));
   endfunction

   function automatic logic [31:0] ref_read(gpio_reg_e sel);
      case (sel)
         GPIO_DIR:   return 32'(m_dir);
         GPIO_IN:    return 32'(m_pins);
         GPIO_IMASK: return 32'(m_imask);
         GPIO_ITYPE: return 32'(m_itype);
         GPIO_IPOL:  return 32'(m_ipol);
         GPIO_ILAT:  return 32'(m_ilat);
         default:    return 32'd0;      // Write-only and unused codes
      endcase
   endfunction

   // ########################################################################
   // Checks and stimulus
   // ########################################################################
   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         value_errs++;
         $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic write_reg(input gpio_reg_e sel, input logic [31:0] data);
      emesh_packet_t pkt;
      logic [N-1:0]  d;
      d           = data[N-1:0];         // Upper bits ignored by the DUT
      pkt         = '0;
      pkt.write   = 1'b1;
      pkt.dstaddr = {25'd0, sel, 3'b000};
      pkt.data    = data;
      pkt.srcaddr = $urandom;
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= pkt;
      n_trans++;
      @(posedge clk);                    // Request taken here
      access_in <= 1'b0;
      case (sel)
         GPIO_DIR:     m_dir   = d;
         GPIO_IMASK:   m_imask = d;
         GPIO_ITYPE:   m_itype = d;
         GPIO_IPOL:    m_ipol  = d;
         GPIO_ILATCLR: m_ilat  = m_ilat & ~d;
         default:      ;
      endcase
      m_out        = out_op(sel, m_out, d);
      m_ilat       = m_ilat | level_hits(m_itype, m_ipol, m_pins);  // Event wins
      pins_pending = 1'b1;
   endtask

   task automatic read_reg(input logic [3:0] code, input int hold);
      emesh_packet_t pkt;
      emesh_packet_t held;
      logic [31:0]   src;
      int            wait_cyc;
      src         = $urandom;
      pkt         = '0;
      pkt.srcaddr = src;
      pkt.dstaddr = {25'd0, code, 3'b000};
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= pkt;
      n_trans++;
      @(posedge clk);                    // Value frozen at this edge
      access_in <= 1'b0;
      wait_in   <= (hold > 0);
      exp_q.push_back({src, ref_read(gpio_reg_e'(code))});
      n_reads++;
      wait_cyc = 0;
      while (!access_out && wait_cyc < 20) begin
         @(negedge clk);
         wait_cyc++;
      end
      assert (access_out) else begin
         proto_errs++;
         $display("No response to a read of register code %0d at %0t", code, $time);
      end
      held = packet_out;
      repeat (hold) begin                // Stalled response must sit still
         @(negedge clk);
         check_val("wait_out", 32'(wait_out), 32'(wait_in));
         check_val("access_out", 32'(access_out), 32'd1);
         assert (packet_out === held) else begin
            value_errs++;
            $display("Fail at %0t: packet_out got %h expected %h", $time, packet_out, held);
         end
      end
      if (hold > 0) begin
         @(posedge clk);
         wait_in <= 1'b0;
         @(negedge clk);
         check_val("wait_out", 32'(wait_out), 32'd0);   // Released with wait_in
      end
      while (resp_count != n_reads && wait_cyc < 40) begin
         @(negedge clk);
         wait_cyc++;
      end
      assert (resp_count == n_reads) else begin
         proto_errs++;
         $display("Response to register code %0d was never consumed", code);
      end
   endtask

   task automatic set_pins(input logic [N-1:0] v);
      @(posedge clk);
      gpio_in <= v;
      m_ilat = m_ilat | edge_hits(m_itype, m_ipol, m_pins, v)
                      | level_hits(m_itype, m_ipol, v);
      m_pins = v;
      repeat (5) @(posedge clk);         // Sync plus latch, with slack
   endtask

   task automatic check_irq;
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_val("gpio_irq", 32'(gpio_irq), 32'(|(m_ilat & ~m_imask)));
   endtask

   // ########################################################################
   // Compare process
   // ########################################################################
   always @(negedge clk) begin
      if (pins_pending) begin
         check_val("gpio_out", 32'(gpio_out), 32'(m_out));
         check_val("gpio_dir", 32'(gpio_dir), 32'(m_dir));
         pins_pending = 1'b0;
      end
   end

   // Consumed on edges with access_out high and wait_in low
   always @(posedge clk) begin
      logic [63:0] e;
      if (nreset && access_out && !wait_in) begin
         assert (exp_q.size() != 0) else begin
            proto_errs++;
            $display("Response at %0t with no read outstanding", $time);
         end
         if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_val("packet_out.write", 32'(packet_out.write), 32'd1);
            check_val("packet_out.dstaddr", packet_out.dstaddr, e[63:32]);
            check_val("packet_out.data", packet_out.data, e[31:0]);
            check_val("packet_out.srcaddr", packet_out.srcaddr, 32'd0);
            check_val("packet_out.ctrlmode", 32'(packet_out.ctrlmode), 32'd0);
            check_val("packet_out.datamode", 32'(packet_out.datamode), 32'd0);
         end
         resp_count++;
      end
   end

   // Watchdog, limit grows with the transactions issued
   initial begin
      while (cycles <= 200 * n_trans + 2000) begin
         @(posedge clk);
         cycles++;
      end
      $display("Watchdog expired after %0d cycles and %0d transactions", cycles, n_trans);
      $display("Finished with errors");
      $finish;
   end

   // ########################################################################
   // Test sequence
   // ########################################################################
   initial begin
      gpio_reg_e sel;
      seed = 32'haf8b;
      void'($urandom(seed));
      nreset       = 1'b0;
      access_in    = 1'b0;
      packet_in    = '0;
      wait_in      = 1'b0;
      gpio_in      = '0;
      pins_pending = 1'b0;
      m_dir        = '0;
      m_out        = '0;
      m_imask      = '1;                 // Everything masked after reset
      m_itype      = '0;
      m_ipol       = '0;
      m_ilat       = '0;
      m_pins       = '0;
      repeat (10) @(posedge clk);
      nreset <= 1'b1;
      repeat (2) @(posedge clk);

      // Reset state
      @(negedge clk);
      check_val("gpio_out", 32'(gpio_out), 32'd0);
      check_val("gpio_dir", 32'(gpio_dir), 32'd0);
      check_val("gpio_irq", 32'(gpio_irq), 32'd0);
      check_val("access_out", 32'(access_out), 32'd0);
      read_reg(GPIO_DIR, 0);
      read_reg(GPIO_ILAT, 0);
      read_reg(GPIO_ITYPE, 0);
      read_reg(GPIO_IPOL, 0);
      read_reg(GPIO_IMASK, 0);

      // Output operations, random data beyond bit N-1
      repeat (200) begin
         case ($urandom_range(0, 4))
            0:       sel = GPIO_OUT;
            1:       sel = GPIO_OUTSET;
            2:       sel = GPIO_OUTCLR;
            3:       sel = GPIO_OUTXOR;
            default: sel = GPIO_DIR;
         endcase
         write_reg(sel, $urandom);
      end
      read_reg(GPIO_DIR, 0);

      // Readback of pins, write-only and unused codes
      set_pins(N'($urandom));
      read_reg(GPIO_IN, 0);
      for (int c = 2; c < 16; c++) begin
         if (c < 6 || c > 9)
            read_reg(c[3:0], 0);
      end

      // Edge interrupts
      write_reg(GPIO_ILATCLR, '1);
      write_reg(GPIO_IPOL, $urandom);
      repeat (20) begin
         set_pins(m_pins ^ N'($urandom));
         read_reg(GPIO_ILAT, 0);
         write_reg(GPIO_IMASK, $urandom);
         check_irq();
         write_reg(GPIO_ILATCLR, $urandom);   // Partial clear
         check_irq();
         read_reg(GPIO_ILAT, 0);
      end

      // Level interrupts
      write_reg(GPIO_ITYPE, '1);
      read_reg(GPIO_ILAT, 0);
      write_reg(GPIO_ILATCLR, '1);       // Active pins set again
      repeat (5) @(posedge clk);
      read_reg(GPIO_ILAT, 0);
      set_pins(~m_ipol);                 // All pins inactive
      write_reg(GPIO_ILATCLR, '1);
      read_reg(GPIO_ILAT, 0);
      repeat (5) @(posedge clk);
      read_reg(GPIO_ILAT, 0);

      // Back-pressure on the response
      repeat (12)
         read_reg(4'($urandom_range(0, 15)), $urandom_range(1, 8));

      repeat (5) @(posedge clk);
      $display("Value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
      if (value_errs + proto_errs == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire
